/* verilog.f */
ooo_pkg.sv
issue.sv
scoreboard.sv
commit.sv
issue_stage.sv
tb_issue_stage.sv

/* Makefile */
# Verilator build for the issue stage testbench.

VERILATOR  ?= verilator
TOP        ?= tb_issue_stage
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --timing -Wall

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The log decides pass or fail.
sim: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_issue_stage.sv */
`timescale 1ns/1ps

module tb_issue_stage
  import ooo_pkg::*;
();

  localparam int NrEntries     = 8;
  localparam int NrWbPorts     = 2;
  localparam int ProgLen       = 200;
  localparam int TimeoutCycles = ProgLen * 20;
  localparam int HoldStart     = 100;  // Independent stretch that fills the scoreboard.
  localparam int HoldLen       = 16;

  logic                       clock;
  logic                       rst;
  decoder_t                   idu2isu_instr;
  logic                       idu2isu_valid;
  logic                       isu2idu_ready;
  fu_data_t                   fu_data;
  logic                       flu_ready;
  logic                       lsu_ready;
  logic                       alu_valid;
  logic                       lsu_valid;
  writeback_t [NrWbPorts-1:0] wb;
  logic                       retire_valid;
  logic [31:0]                retire_pc;
  logic [4:0]                 retire_rd;
  logic [31:0]                retire_wdata;

  decoder_t               prog      [ProgLen];
  logic [31:0]            exp_wdata [ProgLen];
  logic [31:0]            fu_result [ProgLen];
  logic [TransIdBits-1:0] tag_of    [ProgLen];
  int                     due_cycle [ProgLen];
  int                     wb_cycle  [ProgLen];  // Cycle in which the result was driven.
  int                     pending_q [$];
  logic [31:0]            arch      [32];
  logic [31:0]            lfsr_state = 32'h98c5_52b8;
  int                     cycle      = 0;
  int                     disp_cnt   = 0;
  int                     ret_cnt    = 0;
  int                     occupancy  = 0;
  logic                   full_seen  = 1'b0;
  logic                   withhold   = 1'b0;

  issue_stage #(.NrEntries(NrEntries), .NrWbPorts(NrWbPorts)) dut0 (.*);

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] execute(fu_op_e op, logic [31:0] a, logic [31:0] b,
                                          logic [31:0] imm);
    logic [31:0] addr;
    addr = a + imm;
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_XOR: return a ^ b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_SLL: return a << b[4:0];
      default: return {addr[24:0], addr[31:25]} ^ 32'h5a3c_96e1;  // Load memory contents.
    endcase
  endfunction

  // Architectural write value of the next instruction in program order.
  function automatic logic [31:0] reference_result(decoder_t ins);
    logic [31:0] b;
    b = ins.use_imm ? ins.imm : arch[ins.rs2];
    return (ins.rd == 5'd0) ? 32'd0 : execute(ins.op, arch[ins.rs1], b, ins.imm);
  endfunction

  // True when the youngest in-flight writer of rs has its result in.
  function automatic logic source_clear(logic [4:0] rs);
    logic clear;
    logic found;
    clear = 1'b1;
    found = 1'b0;
    if (rs != 5'd0) begin
      for (int j = disp_cnt - 1; j >= ret_cnt; j--) begin
        if (!found && prog[j].rd == rs) begin
          found = 1'b1;
          clear = (wb_cycle[j] < cycle);
        end
      end
    end
    return clear;
  endfunction

  task automatic stop_run();
    $display("sim failed");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    stop_run();
  endtask

  task automatic report_error(string what);
    $display("Error at %0t: %s", $time, what);
    stop_run();
  endtask

  task automatic expect_flag(string name, logic got, logic exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_fu_data(fu_data_t got, fu_data_t exp);
    if (got.fu !== exp.fu) report_mismatch("fu_data.fu", 32'(got.fu), 32'(exp.fu));
    if (got.op !== exp.op) report_mismatch("fu_data.op", 32'(got.op), 32'(exp.op));
    if (got.operand_a !== exp.operand_a)
      report_mismatch("fu_data.operand_a", got.operand_a, exp.operand_a);
    if (got.operand_b !== exp.operand_b)
      report_mismatch("fu_data.operand_b", got.operand_b, exp.operand_b);
    if (got.imm !== exp.imm) report_mismatch("fu_data.imm", got.imm, exp.imm);
    if (got.trans_id !== exp.trans_id)
      report_mismatch("fu_data.trans_id", 32'(got.trans_id), 32'(exp.trans_id));
  endtask

  task automatic check_retire(logic [31:0] pc, logic [4:0] rd, logic [31:0] wdata);
    if (ret_cnt >= disp_cnt) begin
      report_error("retire_valid pulsed with no instruction in flight");
    end else begin
      if (pc !== prog[ret_cnt].pc) report_mismatch("retire_pc", pc, prog[ret_cnt].pc);
      if (rd !== prog[ret_cnt].rd) report_mismatch("retire_rd", 32'(rd), 32'(prog[ret_cnt].rd));
      if (wdata !== exp_wdata[ret_cnt])
        report_mismatch("retire_wdata", wdata, exp_wdata[ret_cnt]);
    end
  endtask

  task automatic check_dispatch();
    decoder_t    cur;
    fu_data_t    exp;
    logic        exp_ready;
    logic        rs2_used;
    logic [31:0] d;
    cur       = prog[disp_cnt];
    rs2_used  = (cur.fu == FU_ALU) && !cur.use_imm;
    exp_ready = (occupancy < NrEntries) && source_clear(cur.rs1) &&
                (!rs2_used || source_clear(cur.rs2)) &&
                ((cur.fu == FU_ALU) ? flu_ready : lsu_ready);
    expect_flag("isu2idu_ready", isu2idu_ready, exp_ready);
    expect_flag("alu_valid", alu_valid, exp_ready && cur.fu == FU_ALU);
    expect_flag("lsu_valid", lsu_valid, exp_ready && cur.fu == FU_LSU);
    if (exp_ready) begin
      exp.fu        = cur.fu;
      exp.op        = cur.op;
      exp.operand_a = arch[cur.rs1];
      exp.operand_b = cur.use_imm ? cur.imm : arch[cur.rs2];
      exp.imm       = cur.imm;
      exp.trans_id  = TransIdBits'(disp_cnt % NrEntries);  // Slots are handed out in order.
      check_fu_data(fu_data, exp);
      exp_wdata[disp_cnt] = reference_result(cur);
      if (cur.rd != 5'd0) arch[cur.rd] = exp_wdata[disp_cnt];
      tag_of[disp_cnt]    = fu_data.trans_id;
      fu_result[disp_cnt] = execute(fu_data.op, fu_data.operand_a, fu_data.operand_b,
                                    fu_data.imm);
      draw_bits(3, d);
      due_cycle[disp_cnt] = cycle + 1 + int'(d % 7);
      pending_q.push_back(disp_cnt);
      disp_cnt++;
    end
  endtask

  // Oldest due result per port goes first; shorter delays overtake.
  task automatic drive_writebacks();
    int hit;
    int idx;
    wb = '0;
    if (!withhold) begin
      for (int p = 0; p < NrWbPorts; p++) begin
        hit = -1;
        for (int k = 0; k < pending_q.size(); k++) begin
          idx = pending_q[k];
          if (hit < 0 && int'(prog[idx].fu) == p && due_cycle[idx] <= cycle) hit = k;
        end
        if (hit >= 0) begin
          idx = pending_q[hit];
          wb[p].valid    = 1'b1;
          wb[p].trans_id = tag_of[idx];
          wb[p].result   = fu_result[idx];
          wb_cycle[idx]  = cycle;
          pending_q.delete(hit);
        end
      end
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
    if (cycle >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, %0d of %0d instructions retired",
               cycle, ret_cnt, ProgLen);
      stop_run();
    end
  end

  initial begin
    logic [31:0] r;
    decoder_t    ins;
    rst           = 1'b1;
    idu2isu_valid = 1'b0;
    idu2isu_instr = '0;
    flu_ready     = 1'b0;
    lsu_ready     = 1'b0;
    wb            = '0;
    for (int j = 0; j < 32; j++) arch[j] = '0;
    for (int i = 0; i < ProgLen; i++) begin
      draw_bits(2, r);
      ins.fu = (r[1:0] == 2'd0) ? FU_LSU : FU_ALU;
      draw_bits(3, r);
      ins.op = (ins.fu == FU_LSU) ? LSU_LW : fu_op_e'(3'(r % 6));
      draw_bits(3, r);
      ins.rs1 = {2'b00, r[2:0]};  // Only x0 to x7, so hazards are frequent.
      draw_bits(3, r);
      ins.rs2 = {2'b00, r[2:0]};
      draw_bits(3, r);
      ins.rd = {2'b00, r[2:0]};
      draw_bits(1, r);
      ins.use_imm = (ins.fu == FU_LSU) || r[0];
      draw_bits(32, r);
      ins.imm = r;
      ins.pc  = 32'h0000_1000 + 32'(4 * i);
      if (i >= HoldStart && i < HoldStart + HoldLen) begin
        ins.rs1     = 5'd0;
        ins.use_imm = 1'b1;
      end
      prog[i]     = ins;
      wb_cycle[i] = 2147483647;
    end
    repeat (5) @(posedge clock);
    #1;
    rst = 1'b0;
    while (ret_cnt < ProgLen) begin
      @(posedge clock);
      #1;
      if (disp_cnt < ProgLen) begin
        idu2isu_valid = 1'b1;
        idu2isu_instr = prog[disp_cnt];
      end else begin
        idu2isu_valid = 1'b0;
        idu2isu_instr = '0;
      end
      draw_bits(2, r);
      flu_ready = (r[1:0] != 2'd0);
      draw_bits(2, r);
      lsu_ready = (r[1:0] != 2'd0);
      withhold = (disp_cnt >= HoldStart) && (disp_cnt < HoldStart + HoldLen) && !full_seen;
      drive_writebacks();
    end
    if (!full_seen) begin
      report_error("scoreboard never filled while results were withheld");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

  always @(negedge clock) begin
    if (rst) begin
      expect_flag("alu_valid", alu_valid, 1'b0);
      expect_flag("lsu_valid", lsu_valid, 1'b0);
      expect_flag("retire_valid", retire_valid, 1'b0);
    end else begin
      if (retire_valid) begin
        check_retire(retire_pc, retire_rd, retire_wdata);
        ret_cnt++;
      end
      occupancy = disp_cnt - ret_cnt;  // Entries held in the scoreboard this cycle.
      if (occupancy == NrEntries) full_seen = 1'b1;
      if (idu2isu_valid) begin
        check_dispatch();
      end else begin
        expect_flag("alu_valid", alu_valid, 1'b0);
        expect_flag("lsu_valid", lsu_valid, 1'b0);
      end
    end
  end

endmodule

/* issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_stage
  import ooo_pkg::*;
#(
  parameter int unsigned NrEntries = 8,
  parameter int unsigned NrWbPorts = 2  // Port 0 ALU, port 1 LSU.
) (
  input  logic                       clock,
  input  logic                       rst,

  input  decoder_t                   idu2isu_instr,
  input  logic                       idu2isu_valid,
  output logic                       isu2idu_ready,

  output fu_data_t                   fu_data,
  input  logic                       flu_ready,
  input  logic                       lsu_ready,
  output logic                       alu_valid,
  output logic                       lsu_valid,

  input  writeback_t [NrWbPorts-1:0] wb,

  output logic                       retire_valid,
  output logic [31:0]                retire_pc,
  output logic [4:0]                 retire_rd,
  output logic [31:0]                retire_wdata
);

  logic                   alloc;
  decoder_t               alloc_instr;
  logic [TransIdBits-1:0] alloc_id;
  logic                   full;
  logic                   rs1_pending;
  logic                   rs1_done;
  logic [31:0]            rs1_fwd;
  logic                   rs2_pending;
  logic                   rs2_done;
  logic [31:0]            rs2_fwd;
  logic                   head_valid;
  logic                   head_done;
  decoder_t               head_instr;
  logic [31:0]            head_result;
  logic                   head_release;
  logic                   gpr_we;
  logic [4:0]             gpr_waddr;
  logic [31:0]            gpr_wdata;

  issue issue0 (
    .clock, .rst,
    .idu2isu_instr, .idu2isu_valid, .isu2idu_ready,
    .fu_data, .flu_ready, .lsu_ready, .alu_valid, .lsu_valid,
    .rs1_pending, .rs1_done, .rs1_fwd,
    .rs2_pending, .rs2_done, .rs2_fwd,
    .full, .alloc_id, .alloc, .alloc_instr,
    .gpr_we, .gpr_waddr, .gpr_wdata
  );

  scoreboard #(
    .NrEntries (NrEntries),
    .NrWbPorts (NrWbPorts)
  ) scoreboard0 (
    .clock, .rst,
    .alloc, .alloc_instr, .alloc_id, .full,
    .rs1 (alloc_instr.rs1),  // Lookups follow the instruction at the decoder.
    .rs1_pending, .rs1_done, .rs1_fwd,
    .rs2 (alloc_instr.rs2),
    .rs2_pending, .rs2_done, .rs2_fwd,
    .wb,
    .head_valid, .head_done, .head_instr, .head_result, .head_release
  );

  commit commit0 (
    .clock, .rst,
    .head_valid, .head_done, .head_instr, .head_result, .head_release,
    .gpr_we, .gpr_waddr, .gpr_wdata,
    .retire_valid, .retire_pc, .retire_rd, .retire_wdata
  );

endmodule

`default_nettype wire

/* commit.sv */
`timescale 1ns/1ps
`default_nettype none

module commit
  import ooo_pkg::*;
(
  input  logic        clock,
  input  logic        rst,

  input  logic        head_valid,
  input  logic        head_done,
  input  decoder_t    head_instr,
  input  logic [31:0] head_result,
  output logic        head_release,

  output logic        gpr_we,
  output logic [4:0]  gpr_waddr,
  output logic [31:0] gpr_wdata,

  output logic        retire_valid,
  output logic [31:0] retire_pc,
  output logic [4:0]  retire_rd,
  output logic [31:0] retire_wdata
);

  // Oldest entry leaves as soon as its result is in.
  assign head_release = head_valid && head_done;

  assign gpr_we    = head_release && (head_instr.rd != 5'd0);
  assign gpr_waddr = head_instr.rd;
  assign gpr_wdata = head_result;

  always_ff @(posedge clock) begin
    if (rst) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= head_release;
    end
  end

  always_ff @(posedge clock) begin
    if (head_release) begin
      retire_pc    <= head_instr.pc;
      retire_rd    <= head_instr.rd;
      retire_wdata <= (head_instr.rd == 5'd0) ? 32'd0 : head_result;  // x0 stays zero.
    end
  end

  // An unfinished head stays in place until its result arrives.
  assert property (@(posedge clock) disable iff (rst)
    head_valid && !head_done |=> head_valid && head_instr == $past(head_instr));

endmodule

`default_nettype wire

/* scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module scoreboard
  import ooo_pkg::*;
#(
  parameter int unsigned NrEntries = 8,
  parameter int unsigned NrWbPorts = 2
) (
  input  logic                                 clock,
  input  logic                                 rst,

  input  logic                                 alloc,
  input  decoder_t                             alloc_instr,
  output logic [TransIdBits-1:0]               alloc_id,
  output logic                                 full,

  input  logic [4:0]                           rs1,
  output logic                                 rs1_pending,
  output logic                                 rs1_done,
  output logic [31:0]                          rs1_fwd,
  input  logic [4:0]                           rs2,
  output logic                                 rs2_pending,
  output logic                                 rs2_done,
  output logic [31:0]                          rs2_fwd,

  input  writeback_t [NrWbPorts-1:0]           wb,

  output logic                                 head_valid,
  output logic                                 head_done,
  output decoder_t                             head_instr,
  output logic [31:0]                          head_result,
  input  logic                                 head_release
);

  localparam int unsigned IdxBits = $clog2(NrEntries);

  logic [NrEntries-1:0] valid;
  logic [NrEntries-1:0] done;
  decoder_t             instr  [NrEntries];
  logic [31:0]          result [NrEntries];
  logic [IdxBits-1:0]   head;
  logic [IdxBits-1:0]   tail;
  logic [IdxBits:0]     count;

  logic [4:0]           look_rs      [2];
  logic                 look_pending [2];
  logic                 look_done    [2];
  logic [31:0]          look_fwd     [2];

  assign alloc_id = TransIdBits'(tail);
  assign full     = (count == (IdxBits + 1)'(NrEntries));

  always_ff @(posedge clock) begin
    if (rst) begin
      valid <= '0;
      done  <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (alloc) begin
        valid[tail] <= 1'b1;
        done[tail]  <= 1'b0;
        tail        <= tail + 1'b1;
      end
      for (int p = 0; p < NrWbPorts; p++) begin
        if (wb[p].valid) done[wb[p].trans_id[IdxBits-1:0]] <= 1'b1;
      end
      if (head_release) begin
        valid[head] <= 1'b0;
        head        <= head + 1'b1;
      end
      count <= count + alloc - head_release;
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) instr[tail] <= alloc_instr;
    for (int p = 0; p < NrWbPorts; p++) begin
      if (wb[p].valid) result[wb[p].trans_id[IdxBits-1:0]] <= wb[p].result;
    end
  end

  assign look_rs[0] = rs1;
  assign look_rs[1] = rs2;

  // Walk back from the tail so the first hit is the youngest writer.
  always_comb begin
    logic [IdxBits-1:0] idx;
    for (int s = 0; s < 2; s++) begin
      look_pending[s] = 1'b0;
      look_done[s]    = 1'b0;
      look_fwd[s]     = '0;
      for (int i = 0; i < NrEntries; i++) begin
        idx = tail - IdxBits'(i + 1);
        if (!look_pending[s] && look_rs[s] != 5'd0 && valid[idx] &&
            instr[idx].rd == look_rs[s]) begin
          look_pending[s] = 1'b1;
          look_done[s]    = done[idx];
          look_fwd[s]     = result[idx];
        end
      end
    end
  end

  assign rs1_pending = look_pending[0];
  assign rs1_done    = look_done[0];
  assign rs1_fwd     = look_fwd[0];
  assign rs2_pending = look_pending[1];
  assign rs2_done    = look_done[1];
  assign rs2_fwd     = look_fwd[1];

  assign head_valid  = valid[head];
  assign head_done   = done[head];
  assign head_instr  = instr[head];
  assign head_result = result[head];

  for (genvar p = 0; p < NrWbPorts; p++) begin : g_wb_check
    // Units only answer for tags that are issued and still open.
    assert property (@(posedge clock) disable iff (rst)
      wb[p].valid |-> valid[wb[p].trans_id[IdxBits-1:0]] &&
                      !done[wb[p].trans_id[IdxBits-1:0]]);
  end

  assert property (@(posedge clock) disable iff (rst) alloc |-> !full);

endmodule

`default_nettype wire

/* issue.sv */
`timescale 1ns/1ps
`default_nettype none

module issue
  import ooo_pkg::*;
(
  input  logic                   clock,
  input  logic                   rst,

  input  decoder_t               idu2isu_instr,
  input  logic                   idu2isu_valid,
  output logic                   isu2idu_ready,

  output fu_data_t               fu_data,
  input  logic                   flu_ready,
  input  logic                   lsu_ready,
  output logic                   alu_valid,
  output logic                   lsu_valid,

  input  logic                   rs1_pending,
  input  logic                   rs1_done,
  input  logic [31:0]            rs1_fwd,
  input  logic                   rs2_pending,
  input  logic                   rs2_done,
  input  logic [31:0]            rs2_fwd,

  input  logic                   full,
  input  logic [TransIdBits-1:0] alloc_id,
  output logic                   alloc,
  output decoder_t               alloc_instr,

  input  logic                   gpr_we,
  input  logic [4:0]             gpr_waddr,
  input  logic [31:0]            gpr_wdata
);

  logic [31:0] gpr [1:31];  // x0 is not stored.
  logic [31:0] rs1_value;
  logic [31:0] rs2_value;
  logic        use_rs2;
  logic        rs1_ok;
  logic        rs2_ok;
  logic        unit_ready;

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        gpr[i] <= '0;
      end
    end else if (gpr_we && gpr_waddr != 5'd0) begin
      gpr[gpr_waddr] <= gpr_wdata;
    end
  end

  // A finished producer in the scoreboard wins over the register file.
  assign rs1_value = (idu2isu_instr.rs1 == 5'd0) ? 32'd0 :
                     rs1_pending ? rs1_fwd : gpr[idu2isu_instr.rs1];
  assign rs2_value = (idu2isu_instr.rs2 == 5'd0) ? 32'd0 :
                     rs2_pending ? rs2_fwd : gpr[idu2isu_instr.rs2];

  assign use_rs2    = (idu2isu_instr.fu == FU_ALU) && !idu2isu_instr.use_imm;
  assign rs1_ok     = !rs1_pending || rs1_done;
  assign rs2_ok     = !use_rs2 || !rs2_pending || rs2_done;
  assign unit_ready = (idu2isu_instr.fu == FU_ALU) ? flu_ready : lsu_ready;

  assign isu2idu_ready = !full && rs1_ok && rs2_ok && unit_ready;
  assign alloc         = idu2isu_valid && isu2idu_ready;
  assign alloc_instr   = idu2isu_instr;

  assign alu_valid = alloc && (idu2isu_instr.fu == FU_ALU);
  assign lsu_valid = alloc && (idu2isu_instr.fu == FU_LSU);

  assign fu_data.fu        = idu2isu_instr.fu;
  assign fu_data.op        = idu2isu_instr.op;
  assign fu_data.operand_a = rs1_value;
  assign fu_data.operand_b = idu2isu_instr.use_imm ? idu2isu_instr.imm : rs2_value;
  assign fu_data.imm       = idu2isu_instr.imm;
  assign fu_data.trans_id  = alloc_id;

  // The decoder holds a stalled instruction until it is taken.
  assert property (@(posedge clock) disable iff (rst)
    idu2isu_valid && !isu2idu_ready |=> idu2isu_valid && $stable(idu2isu_instr));

endmodule

`default_nettype wire

/* ooo_pkg.sv */
package ooo_pkg;

  // Transaction tag width caps the scoreboard at eight entries.
  localparam int unsigned TransIdBits = 3;

  typedef enum logic {
    FU_ALU = 1'b0,
    FU_LSU = 1'b1
  } fu_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_XOR = 3'd2,
    ALU_AND = 3'd3,
    ALU_OR  = 3'd4,
    ALU_SLL = 3'd5,
    LSU_LW  = 3'd6
  } fu_op_e;

  // Decoded instruction as handed over by the decoder.
  typedef struct packed {
    fu_e         fu;
    fu_op_e      op;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic        use_imm;  // Operand b is the immediate.
    logic [31:0] pc;
  } decoder_t;

  // Operation sent to the ALU or the LSU.
  typedef struct packed {
    fu_e                    fu;
    fu_op_e                 op;
    logic [31:0]            operand_a;
    logic [31:0]            operand_b;
    logic [31:0]            imm;    // Address offset for loads.
    logic [TransIdBits-1:0] trans_id;
  } fu_data_t;

  // One result returning from a functional unit.
  typedef struct packed {
    logic                   valid;
    logic [TransIdBits-1:0] trans_id;
    logic [31:0]            result;
  } writeback_t;

endpackage
